// ==== fsq_cfg.svh ====
`ifndef FSQ_CFG_SVH
`define FSQ_CFG_SVH

// ring geometry
`define FSQ_DEPTH 16
`define FSQ_IDX_W 4

// virtual address width
`define VADDR_W 32

// 8 instructions per stream
`define OFFSET_W 3

// backend retire width
`define COMMIT_W 4

// retired-instruction accumulator
`define CNT_W 5

`endif

// ==== fetch_stream_pkg.sv ====
`default_nettype none

`include "fsq_cfg.svh"

package fetch_stream_pkg;

    // one predicted fetch stream
    typedef struct packed {
        logic [`VADDR_W-1:0]  start_addr;
        // offset of the last instruction
        logic [`OFFSET_W-1:0] size;
        logic                 taken;
        logic [`VADDR_W-1:0]  target;
    } fetch_stream_t;

endpackage

`default_nettype wire

// ==== fsq_ctrl_pkg.sv ====
`default_nettype none

`include "fsq_cfg.svh"

package fsq_ctrl_pkg;

    import fetch_stream_pkg::*;

    // ring index plus wrap bit
    typedef struct packed {
        logic [`FSQ_IDX_W-1:0] idx;
        logic                  dir;
    } fsq_ptr_t;

    typedef struct packed {
        fsq_ptr_t      ptr;
        fetch_stream_t stream;
    } fetch_req_t;

    // resolved branch from the backend
    typedef struct packed {
        fsq_ptr_t             ptr;
        logic [`OFFSET_W-1:0] offset;
        logic                 taken;
        logic [`VADDR_W-1:0]  target;
    } redirect_t;

    typedef struct packed {
        fsq_ptr_t      ptr;
        fetch_stream_t stream;
        logic          mispredict;
    } update_t;

    // next slot, dir flips when the index wraps
    function automatic fsq_ptr_t ptr_inc(fsq_ptr_t p);
        fsq_ptr_t n;
        n.idx = p.idx + 1'b1;
        n.dir = (p.idx == `FSQ_IDX_W'(`FSQ_DEPTH - 1)) ? ~p.dir : p.dir;
        return n;
    endfunction

endpackage

`default_nettype wire

// ==== fsq_ptr_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fsq_cfg.svh"

module fsq_ptr_ctrl
    import fsq_ctrl_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     pred_valid,
    input  wire logic     redir_valid,
    input  wire fsq_ptr_t redir_ptr,
    input  wire logic     retire,
    output logic          pred_ready,
    output logic          enq_fire,
    output fsq_ptr_t      tail_ptr,
    output fsq_ptr_t      head_ptr
);

    logic                full;
    logic                empty;
    logic [`FSQ_IDX_W:0] used;

    // same slot, different lap
    assign full = (head_ptr.idx == tail_ptr.idx) && (head_ptr.dir != tail_ptr.dir);
    assign empty = (head_ptr == tail_ptr);

    // occupancy from the wrap-extended pointers
    assign used = {tail_ptr.dir, tail_ptr.idx} - {head_ptr.dir, head_ptr.idx};

    assign pred_ready = ~full;
    assign enq_fire = pred_valid & pred_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail_ptr <= '0;
        end else if (redir_valid) begin
            // younger streams are dropped
            tail_ptr <= ptr_inc(redir_ptr);
        end else if (enq_fire) begin
            tail_ptr <= ptr_inc(tail_ptr);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_ptr <= '0;
        end else if (retire) begin
            head_ptr <= ptr_inc(head_ptr);
        end
    end

    // commit logic must only retire enqueued streams
    assert property (@(posedge clk) disable iff (rst) retire |-> !empty)
        else $error("retire on an empty queue");

    // tail never laps the head, whatever retires or redirects do
    assert property (@(posedge clk) disable iff (rst)
        used <= (`FSQ_IDX_W + 1)'(`FSQ_DEPTH))
        else $error("tail moved more than one ring ahead of the head");

endmodule

`default_nettype wire

// ==== fsq_fetch_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fsq_cfg.svh"

module fsq_fetch_issue
    import fetch_stream_pkg::*;
    import fsq_ctrl_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire fsq_ptr_t      tail_ptr,
    input  wire fetch_stream_t search_stream,
    input  wire logic          redir_valid,
    input  wire fsq_ptr_t      redir_ptr,
    input  wire logic          fetch_ready,
    output fsq_ptr_t           search_ptr,
    output logic               fetch_valid,
    output fetch_req_t         fetch_req
);

    fsq_ptr_t            issue_ptr;
    logic                has_work;
    logic                load;
    logic [`FSQ_IDX_W:0] unissued;

    assign search_ptr = issue_ptr;

    // streams between the issue pointer and the tail are still unissued
    assign has_work = (issue_ptr != tail_ptr);
    assign load = has_work & (~fetch_valid | fetch_ready);

    assign unissued = {tail_ptr.dir, tail_ptr.idx} - {issue_ptr.dir, issue_ptr.idx};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_ptr <= '0;
            fetch_valid <= 1'b0;
        end else if (redir_valid) begin
            issue_ptr <= ptr_inc(redir_ptr);
            fetch_valid <= 1'b0;
        end else if (load) begin
            issue_ptr <= ptr_inc(issue_ptr);
            fetch_valid <= 1'b1;
        end else if (fetch_ready) begin
            fetch_valid <= 1'b0;
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (!redir_valid && load) begin
            fetch_req.ptr <= issue_ptr;
            fetch_req.stream <= search_stream;
        end
    end

    // issue pointer stays inside the live ring window
    assert property (@(posedge clk) disable iff (rst)
        unissued <= (`FSQ_IDX_W + 1)'(`FSQ_DEPTH))
        else $error("issue pointer left the queue window");

endmodule

`default_nettype wire

// ==== fsq_stream_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fsq_cfg.svh"

module fsq_stream_ram
    import fetch_stream_pkg::*;
    import fsq_ctrl_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          wr_en,
    input  wire fsq_ptr_t      wr_ptr,
    input  wire fetch_stream_t wr_stream,
    input  wire logic          redir_valid,
    input  wire redirect_t     redir,
    input  wire fsq_ptr_t      search_ptr,
    input  wire fsq_ptr_t      head_ptr,
    output fetch_stream_t      search_stream,
    output fetch_stream_t      head_stream,
    output logic               head_mispredict
);

    fetch_stream_t            mem [`FSQ_DEPTH];
    logic [`FSQ_DEPTH-1:0]    mispredict;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr.idx] <= wr_stream;
        end
        // truncate to the resolved branch
        if (redir_valid) begin
            mem[redir.ptr.idx].size <= redir.offset;
            mem[redir.ptr.idx].taken <= redir.taken;
            mem[redir.ptr.idx].target <= redir.target;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mispredict <= '0;
        end else begin
            if (wr_en) begin
                mispredict[wr_ptr.idx] <= 1'b0;
            end
            if (redir_valid) begin
                mispredict[redir.ptr.idx] <= 1'b1;
            end
        end
    end

    // issue and commit read ports
    assign search_stream = mem[search_ptr.idx];
    assign head_stream = mem[head_ptr.idx];
    assign head_mispredict = mispredict[head_ptr.idx];

endmodule

`default_nettype wire

// ==== fsq_commit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fsq_cfg.svh"

module fsq_commit
    import fetch_stream_pkg::*;
    import fsq_ctrl_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [`COMMIT_W:0]   commit_num,
    input  wire fsq_ptr_t             head_ptr,
    input  wire fetch_stream_t        head_stream,
    input  wire logic                 head_mispredict,
    output logic                      retire,
    output logic                      upd_valid,
    output update_t                   upd
);

    logic [`CNT_W-1:0] acc;
    logic [`CNT_W:0]   sum;
    logic [`CNT_W:0]   need;
    logic [`CNT_W:0]   acc_next;

    // retired so far, this cycle included
    assign sum = {1'b0, acc} + (`CNT_W + 1)'(commit_num);

    // instructions in the head stream
    assign need = (`CNT_W + 1)'(head_stream.size) + 1'b1;

    assign retire = (sum >= need);
    assign acc_next = retire ? (sum - need) : sum;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else begin
            acc <= acc_next[`CNT_W-1:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            upd_valid <= 1'b0;
        end else begin
            upd_valid <= retire;
        end
    end

    // size already carries the redirect truncation
    always_ff @(posedge clk) begin
        if (retire) begin
            upd.ptr <= head_ptr;
            upd.stream <= head_stream;
            upd.mispredict <= head_mispredict;
        end
    end

    // backend must not run ahead of the queued streams
    assert property (@(posedge clk) disable iff (rst) !acc_next[`CNT_W])
        else $error("commit accumulator overflow");

endmodule

`default_nettype wire

// ==== fsq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fsq_cfg.svh"

module fsq_top
    import fetch_stream_pkg::*;
    import fsq_ctrl_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    // predictor
    input  wire logic               pred_valid,
    input  wire fetch_stream_t      pred_stream,
    output logic                    pred_ready,
    output fsq_ptr_t                pred_tail,
    // instruction cache
    output logic                    fetch_valid,
    output fetch_req_t              fetch_req,
    input  wire logic               fetch_ready,
    // backend
    input  wire logic               redir_valid,
    input  wire redirect_t          redir,
    input  wire logic [`COMMIT_W:0] commit_num,
    // predictor update
    output logic                    upd_valid,
    output update_t                 upd
);

    fsq_ptr_t      tail_ptr;
    fsq_ptr_t      head_ptr;
    fsq_ptr_t      search_ptr;
    fetch_stream_t search_stream;
    fetch_stream_t head_stream;
    logic          head_mispredict;
    logic          enq_fire;
    logic          retire;

    assign pred_tail = tail_ptr;

    fsq_ptr_ctrl ptr_ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .pred_valid  (pred_valid),
        .redir_valid (redir_valid),
        .redir_ptr   (redir.ptr),
        .retire      (retire),
        .pred_ready  (pred_ready),
        .enq_fire    (enq_fire),
        .tail_ptr    (tail_ptr),
        .head_ptr    (head_ptr)
    );

    fsq_fetch_issue fetch_issue_inst (
        .clk           (clk),
        .rst           (rst),
        .tail_ptr      (tail_ptr),
        .search_stream (search_stream),
        .redir_valid   (redir_valid),
        .redir_ptr     (redir.ptr),
        .fetch_ready   (fetch_ready),
        .search_ptr    (search_ptr),
        .fetch_valid   (fetch_valid),
        .fetch_req     (fetch_req)
    );

    fsq_stream_ram stream_ram_inst (
        .clk             (clk),
        .rst             (rst),
        .wr_en           (enq_fire),
        .wr_ptr          (tail_ptr),
        .wr_stream       (pred_stream),
        .redir_valid     (redir_valid),
        .redir           (redir),
        .search_ptr      (search_ptr),
        .head_ptr        (head_ptr),
        .search_stream   (search_stream),
        .head_stream     (head_stream),
        .head_mispredict (head_mispredict)
    );

    fsq_commit commit_inst (
        .clk             (clk),
        .rst             (rst),
        .commit_num      (commit_num),
        .head_ptr        (head_ptr),
        .head_stream     (head_stream),
        .head_mispredict (head_mispredict),
        .retire          (retire),
        .upd_valid       (upd_valid),
        .upd             (upd)
    );

endmodule

`default_nettype wire

// ==== fsq_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fsq_cfg.svh"

module fsq_checker
    import fetch_stream_pkg::*;
    import fsq_ctrl_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               pred_valid,
    input  wire fetch_stream_t      pred_stream,
    input  wire logic               pred_ready,
    input  wire fsq_ptr_t           pred_tail,
    input  wire logic               fetch_valid,
    input  wire fetch_req_t         fetch_req,
    input  wire logic               fetch_ready,
    input  wire logic               redir_valid,
    input  wire redirect_t          redir,
    input  wire logic [`COMMIT_W:0] commit_num,
    input  wire logic               upd_valid,
    input  wire update_t            upd,
    input  wire logic               report_req,
    output logic                    report_done,
    output int                      error_total
);

    // seq counts slots over two laps, its top bit is the wrap bit
    typedef struct packed {
        logic [`FSQ_IDX_W:0] seq;
        fetch_stream_t       stream;
        logic                misp;
    } entry_t;

    entry_t              model_q[$];
    logic [`FSQ_IDX_W:0] tail_seq;
    int                  issued;
    int                  acc;
    int                  laps;
    int                  checks [1:6];
    int                  errors [1:6];
    logic                upd_pending;
    entry_t              upd_exp;
    logic                stall_seen;
    fetch_req_t          stall_req;
    logic                redir_seen;
    logic                after_redir;

    function automatic fsq_ptr_t seq_to_ptr(logic [`FSQ_IDX_W:0] seq);
        fsq_ptr_t p;
        p.idx = seq[`FSQ_IDX_W-1:0];
        p.dir = seq[`FSQ_IDX_W];
        return p;
    endfunction

    task automatic check_value(int t, string name, logic [127:0] want, logic [127:0] got);
        checks[t]++;
        if (want !== got) begin
            errors[t]++;
            $display("error at %0d ns: %s expected %0h got %0h", $time, name, want, got);
        end
    endtask

    task automatic note_failure(int t, string what);
        checks[t]++;
        errors[t]++;
        $display("failure at %0d ns: %s", $time, what);
    endtask

    // sampled at the falling edge, where ports are settled for the next rising edge
    always @(negedge clk) begin : model_step
        int     sum;
        int     k;
        int     total_checks;
        logic   retire_now;
        entry_t e;
        if (rst) begin
            model_q.delete();
            tail_seq = '0;
            issued = 0;
            acc = 0;
            laps = 0;
            upd_pending = 1'b0;
            stall_seen = 1'b0;
            redir_seen = 1'b0;
            after_redir = 1'b0;
            report_done = 1'b0;
            error_total = 0;
            foreach (checks[t]) begin
                checks[t] = 0;
                errors[t] = 0;
            end
        end else begin
            check_value(redir_seen ? 3 : 6, "pred_tail", seq_to_ptr(tail_seq), pred_tail);
            check_value(2, "pred_ready", model_q.size() != `FSQ_DEPTH, pred_ready);
            if (redir_seen) begin
                check_value(3, "fetch_valid", 1'b0, fetch_valid);
            end
            if (stall_seen) begin
                check_value(2, "fetch_valid", 1'b1, fetch_valid);
                check_value(2, "fetch_req", stall_req, fetch_req);
            end
            check_value(4, "upd_valid", upd_pending, upd_valid);
            if (upd_pending && upd_valid) begin
                check_value(5, "upd.ptr", seq_to_ptr(upd_exp.seq), upd.ptr);
                check_value(5, "upd.stream", upd_exp.stream, upd.stream);
                check_value(5, "upd.mispredict", upd_exp.misp, upd.mispredict);
            end

            // head retires once the retired count covers all of its instructions
            sum = acc + int'(commit_num);
            retire_now = (model_q.size() > 0) && (sum >= int'(model_q[0].stream.size) + 1);
            upd_pending = retire_now;
            if (retire_now) begin
                upd_exp = model_q[0];
                acc = sum - (int'(model_q[0].stream.size) + 1);
            end else begin
                acc = sum;
            end

            if (fetch_valid && fetch_ready) begin
                if (issued >= model_q.size()) begin
                    note_failure(1, "fetch request while no stream is waiting for issue");
                end else begin
                    check_value(after_redir ? 3 : 1, "fetch_req.ptr",
                        seq_to_ptr(model_q[issued].seq), fetch_req.ptr);
                    check_value(1, "fetch_req.stream", model_q[issued].stream,
                        fetch_req.stream);
                    issued++;
                end
                after_redir = 1'b0;
            end

            if (pred_valid && !redir_valid && model_q.size() < `FSQ_DEPTH) begin
                e.seq = tail_seq;
                e.stream = pred_stream;
                e.misp = 1'b0;
                model_q.push_back(e);
                tail_seq = tail_seq + 1'b1;
                if (tail_seq[`FSQ_IDX_W-1:0] == '0) begin
                    laps++;
                end
            end

            if (redir_valid) begin
                k = -1;
                foreach (model_q[i]) begin
                    if (seq_to_ptr(model_q[i].seq) == redir.ptr) begin
                        k = i;
                    end
                end
                if (k < 0) begin
                    note_failure(3, "redirect names a pointer that is not in the queue");
                end else begin
                    e = model_q[k];
                    e.stream.size = redir.offset;
                    e.stream.taken = redir.taken;
                    e.stream.target = redir.target;
                    e.misp = 1'b1;
                    model_q[k] = e;
                    // younger streams are gone for good
                    while (model_q.size() > k + 1) begin
                        void'(model_q.pop_back());
                    end
                    tail_seq = e.seq + 1'b1;
                    issued = k + 1;
                end
                after_redir = 1'b1;
            end

            if (retire_now) begin
                void'(model_q.pop_front());
                if (issued == 0) begin
                    note_failure(4, "a stream retired before it was issued");
                end else begin
                    issued--;
                end
            end

            stall_seen = fetch_valid && !fetch_ready && !redir_valid;
            stall_req = fetch_req;
            redir_seen = redir_valid;

            if (report_req && !report_done) begin
                if (laps < 3) begin
                    note_failure(6, "the ring wrapped fewer than three times");
                end
                total_checks = 0;
                for (int t = 1; t <= 6; t++) begin
                    $display("test %0d: %0d checks, %0d errors", t, checks[t], errors[t]);
                    total_checks += checks[t];
                    error_total += errors[t];
                end
                $display("%0d checks in total, %0d errors", total_checks, error_total);
                report_done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_fsq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fsq_cfg.svh"

module tb_fsq_top
    import fetch_stream_pkg::*;
    import fsq_ctrl_pkg::*;
();

    localparam int RUN_CYCLES = 3000;
    localparam int DRAIN_LIMIT = 2000;
    localparam int REPORT_LIMIT = 10;

    // a fetched stream the backend is still executing
    typedef struct packed {
        fsq_ptr_t            ptr;
        logic [`OFFSET_W:0]  len;
    } flight_t;

    logic               clk;
    logic               rst;
    logic               pred_valid;
    fetch_stream_t      pred_stream;
    logic               pred_ready;
    fsq_ptr_t           pred_tail;
    logic               fetch_valid;
    fetch_req_t         fetch_req;
    logic               fetch_ready;
    logic               redir_valid;
    redirect_t          redir;
    logic [`COMMIT_W:0] commit_num;
    logic               upd_valid;
    update_t            upd;
    logic               report_req;
    logic               report_done;
    int                 error_total;
    int                 seed;
    flight_t            flight_q[$];
    int                 head_done;
    logic               drain_timeout;

    fsq_top fsq_top_inst (.*);

    fsq_checker checker_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int pick(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic drive_cycle(logic draining);
        int      k;
        int      lo;
        int      n;
        int      room;
        flight_t f;
        pred_valid = 1'b0;
        redir_valid = 1'b0;
        commit_num = '0;
        fetch_ready = draining || pick(4) != 0;
        pred_stream = {$random(seed), `OFFSET_W'(pick(1 << `OFFSET_W)), 1'(pick(2)),
            $random(seed)};
        if (!draining && flight_q.size() > 0 && pick(20) == 0) begin
            // branch resolved inside a fetched stream, past what is already retired
            k = pick(flight_q.size());
            lo = (k == 0) ? head_done : 0;
            f = flight_q[k];
            redir_valid = 1'b1;
            redir.ptr = f.ptr;
            redir.offset = `OFFSET_W'(lo + pick(int'(f.len) - lo));
            redir.taken = 1'(pick(2));
            redir.target = $random(seed);
            fetch_ready = 1'b0;
            while (flight_q.size() > k + 1) begin
                void'(flight_q.pop_back());
            end
            f.len = (`OFFSET_W + 1)'(redir.offset) + 1'b1;
            flight_q[k] = f;
        end else begin
            pred_valid = !draining && pick(3) != 0;
            if (flight_q.size() > 0) begin
                // never past the head stream, so one retirement at a time
                room = int'(flight_q[0].len) - head_done;
                n = pick(`COMMIT_W + 1);
                if (n > room) begin
                    n = room;
                end
                commit_num = (`COMMIT_W + 1)'(n);
                head_done += n;
                if (head_done == int'(flight_q[0].len)) begin
                    void'(flight_q.pop_front());
                    head_done = 0;
                end
            end
        end
    endtask

    task automatic note_fetch();
        flight_t f;
        if (fetch_valid && fetch_ready) begin
            f.ptr = fetch_req.ptr;
            f.len = (`OFFSET_W + 1)'(fetch_req.stream.size) + 1'b1;
            flight_q.push_back(f);
        end
    endtask

    initial begin : stimulus
        int cycles;
        int quiet;
        seed = 32'h53e022a9;
        rst = 1'b1;
        pred_valid = 1'b0;
        pred_stream = '0;
        fetch_ready = 1'b0;
        redir_valid = 1'b0;
        redir = '0;
        commit_num = '0;
        report_req = 1'b0;
        head_done = 0;
        drain_timeout = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        for (cycles = 0; cycles < RUN_CYCLES; cycles++) begin
            drive_cycle(1'b0);
            @(negedge clk);
            note_fetch();
            @(posedge clk);
            #2;
        end
        // no more enqueues, let every stream issue and retire
        quiet = 0;
        cycles = 0;
        while (quiet < 4 && !drain_timeout) begin
            drive_cycle(1'b1);
            @(negedge clk);
            note_fetch();
            quiet = (flight_q.size() == 0 && !fetch_valid) ? quiet + 1 : 0;
            @(posedge clk);
            #2;
            cycles++;
            drain_timeout = (quiet < 4) && (cycles >= DRAIN_LIMIT);
        end
        if (!drain_timeout) begin
            report_req = 1'b1;
            cycles = 0;
            while (!report_done && cycles < REPORT_LIMIT) begin
                @(posedge clk);
                cycles++;
            end
        end
        if (drain_timeout) begin
            $display("the queue did not drain within %0d cycles", DRAIN_LIMIT);
        end else if (!report_done) begin
            $display("the checker gave no report within %0d cycles", REPORT_LIMIT);
        end
        if (drain_timeout || !report_done || error_total != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fsq_top.f ====
+incdir+.
fetch_stream_pkg.sv
fsq_ctrl_pkg.sv
fsq_ptr_ctrl.sv
fsq_fetch_issue.sv
fsq_stream_ram.sv
fsq_commit.sv
fsq_top.sv
fsq_checker.sv
tb_fsq_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the fetch stream queue testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_fsq_top \
    -f fsq_top.f -o sim_fsq || exit 1
out="$(./obj_dir/sim_fsq)"
echo "$out"
echo "$out" | grep -q "TEST PASSED" && exit 0 || exit 1
